// ==== radio_ctrl_pkg.sv ====
// Radio control package with the settings map, widths, reset values and readback indices
package radio_ctrl_pkg;

   // Settings bus
   localparam int unsigned SET_ADDR_W = 8;
   localparam int unsigned SET_DATA_W = 32;

   // Misc register block
   localparam logic [SET_ADDR_W-1:0] SR_MISC        = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_SER_OFS     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_ADC_OFS     = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LED_OFS     = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_PHY_OFS     = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC_OFS = 8'd6;

   // VITA time block, control bit 0 set loads now, clear loads at next PPS
   localparam logic [SET_ADDR_W-1:0] SR_TIME64     = 8'd10;
   localparam logic [SET_ADDR_W-1:0] TIME_HI_OFS   = 8'd0;
   localparam logic [SET_ADDR_W-1:0] TIME_LO_OFS   = 8'd1;
   localparam logic [SET_ADDR_W-1:0] TIME_CTRL_OFS = 8'd2;

   // ATR GPIO block
   localparam logic [SET_ADDR_W-1:0] SR_GPIO      = 8'd184;
   localparam logic [SET_ADDR_W-1:0] ATR_IDLE_OFS = 8'd0;
   localparam logic [SET_ADDR_W-1:0] ATR_RX_OFS   = 8'd1;
   localparam logic [SET_ADDR_W-1:0] ATR_TX_OFS   = 8'd2;
   localparam logic [SET_ADDR_W-1:0] ATR_FDX_OFS  = 8'd3;
   localparam logic [SET_ADDR_W-1:0] ATR_DDR_OFS  = 8'd4;

   // LEDs, a 1 in the source word hands that LED to hardware
   localparam int unsigned LED_W = 8;
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;

   localparam int unsigned GPIO_W = 32;
   localparam int unsigned TIME_W = 64;

   // Readback words
   localparam int unsigned RB_ADDR_W = 4;
   localparam logic [RB_ADDR_W-1:0] RB_GPIO    = 4'd9;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_HI = 4'd10;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_LO = 4'd11;
   localparam logic [RB_ADDR_W-1:0] RB_COMPAT  = 4'd12;
   localparam logic [RB_ADDR_W-1:0] RB_STATUS  = 4'd13;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_HI  = 4'd14;
   localparam logic [RB_ADDR_W-1:0] RB_PPS_LO  = 4'd15;

   // Major in the upper half, minor in the lower half
   localparam logic [SET_DATA_W-1:0] COMPAT_NUM = {16'd9, 16'd0};

endpackage

// ==== setting_reg.sv ====
// Settings register that loads on its own bus address and flags each write
`timescale 1ns/1ns

module setting_reg #(
   parameter logic [radio_ctrl_pkg::SET_ADDR_W-1:0] my_addr = '0,
   parameter int unsigned width = 32,
   parameter logic [width-1:0] at_reset = '0
) (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic                                  set_stb_i,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   output logic [width-1:0]                      value_o,
   output logic                                  changed_o
);

   logic hit;

   // Address decode for this register only
   assign hit = set_stb_i && (set_addr_i == my_addr);

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         value_o   <= at_reset;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            value_o <= set_data_i[width-1:0];
         end
      end
   end

endmodule

// ==== misc_ctrl.sv ====
// Misc control registers for SERDES, ADC, PHY reset and the LED hardware/software select
`timescale 1ns/1ns

module misc_ctrl (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic                                  set_stb_i,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                  run_rx_i,
   input  logic                                  run_tx_i,
   input  logic                                  clk_status_i,
   input  logic                                  serdes_link_up_i,
   input  logic                                  good_sync_i,
   output logic                                  ser_enable_o,
   output logic                                  ser_prbsen_o,
   output logic                                  ser_loopen_o,
   output logic                                  ser_rx_en_o,
   output logic                                  adc_oe_a_o,
   output logic                                  adc_on_a_o,
   output logic                                  adc_oe_b_o,
   output logic                                  adc_on_b_o,
   output logic                                  phy_reset_n_o,
   output logic [radio_ctrl_pkg::LED_W-1:0]      leds_o
);

   logic [3:0]                         ser_bits;
   logic [3:0]                         adc_bits;
   logic                               phy_reset;
   logic [radio_ctrl_pkg::LED_W-1:0]   led_sw;
   logic [radio_ctrl_pkg::LED_W-1:0]   led_src;
   logic [radio_ctrl_pkg::LED_W-1:0]   led_hw;

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::SR_SER_OFS), .width(4)
   ) u_sr_ser (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(ser_bits), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::SR_ADC_OFS), .width(4)
   ) u_sr_adc (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(adc_bits), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::SR_LED_OFS),
      .width(radio_ctrl_pkg::LED_W)
   ) u_sr_led (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(led_sw), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::SR_LED_SRC_OFS),
      .width(radio_ctrl_pkg::LED_W), .at_reset(radio_ctrl_pkg::LED_SRC_RESET)
   ) u_sr_led_src (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(led_src), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_MISC + radio_ctrl_pkg::SR_PHY_OFS), .width(1)
   ) u_sr_phy (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(phy_reset), .changed_o()
   );

   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_bits;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}        = adc_bits;

   // PHY held in reset only while software sets bit 0
   assign phy_reset_n_o = ~phy_reset;

   // Status shown by LEDs under hardware control
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== vita_time_64.sv ====
// 64-bit VITA time counter with immediate or PPS-timed load and PPS time latch
`timescale 1ns/1ns

module vita_time_64 (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic                                  set_stb_i,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                  pps_i,
   output logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time_o,
   output logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time_pps_o,
   output logic                                  pps_int_o,
   output logic                                  good_sync_o
);

   logic [radio_ctrl_pkg::SET_DATA_W-1:0] time_hi;
   logic [radio_ctrl_pkg::SET_DATA_W-1:0] time_lo;
   logic                                  load_now;
   logic                                  ctrl_changed;
   logic [1:0]                            pps_sync;
   logic                                  pps_d;
   logic                                  pps_edge;
   logic                                  armed;

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_HI_OFS),
      .width(radio_ctrl_pkg::SET_DATA_W)
   ) u_sr_hi (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(time_hi), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_LO_OFS),
      .width(radio_ctrl_pkg::SET_DATA_W)
   ) u_sr_lo (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(time_lo), .changed_o()
   );

   // Control write fires the load, bit 0 picks now or next PPS
   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_TIME64 + radio_ctrl_pkg::TIME_CTRL_OFS), .width(1)
   ) u_sr_ctrl (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(load_now), .changed_o(ctrl_changed)
   );

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge detect
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_d;

   ////////////////////////////////////////////////////////////////////////////
   // Counter, arm flag and PPS latch
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed           <= 1'b0;
         good_sync_o     <= 1'b0;
         pps_int_o       <= 1'b0;
      end else begin
         pps_int_o <= pps_edge;
         if (ctrl_changed && load_now) begin
            vita_time_o <= {time_hi, time_lo};
            armed       <= 1'b0;
         end else if (pps_edge && armed) begin
            // Time at this PPS edge is the loaded value
            vita_time_o     <= {time_hi, time_lo};
            vita_time_pps_o <= {time_hi, time_lo};
            armed           <= 1'b0;
            good_sync_o     <= 1'b1;
         end else begin
            vita_time_o <= vita_time_o + 1'b1;
            if (pps_edge) begin
               vita_time_pps_o <= vita_time_o;
            end
            if (ctrl_changed) begin
               armed <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== gpio_atr.sv ====
// ATR GPIO bank, pin outputs follow the idle, rx, tx or full-duplex state
`timescale 1ns/1ns

module gpio_atr (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic                                  set_stb_i,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic                                  run_rx_i,
   input  logic                                  run_tx_i,
   input  logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_i,
   output logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_o,
   output logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_oe_o,
   output logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_readback_o
);

   logic [radio_ctrl_pkg::GPIO_W-1:0] atr_idle;
   logic [radio_ctrl_pkg::GPIO_W-1:0] atr_rx;
   logic [radio_ctrl_pkg::GPIO_W-1:0] atr_tx;
   logic [radio_ctrl_pkg::GPIO_W-1:0] atr_fdx;

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_GPIO + radio_ctrl_pkg::ATR_IDLE_OFS),
      .width(radio_ctrl_pkg::GPIO_W)
   ) u_sr_idle (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(atr_idle), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_GPIO + radio_ctrl_pkg::ATR_RX_OFS),
      .width(radio_ctrl_pkg::GPIO_W)
   ) u_sr_rx (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(atr_rx), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_GPIO + radio_ctrl_pkg::ATR_TX_OFS),
      .width(radio_ctrl_pkg::GPIO_W)
   ) u_sr_tx (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(atr_tx), .changed_o()
   );

   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_GPIO + radio_ctrl_pkg::ATR_FDX_OFS),
      .width(radio_ctrl_pkg::GPIO_W)
   ) u_sr_fdx (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(atr_fdx), .changed_o()
   );

   // Direction, a 1 drives the pin
   setting_reg #(
      .my_addr(radio_ctrl_pkg::SR_GPIO + radio_ctrl_pkg::ATR_DDR_OFS),
      .width(radio_ctrl_pkg::GPIO_W)
   ) u_sr_ddr (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .value_o(gpio_oe_o), .changed_o()
   );

   always_comb begin
      case ({run_tx_i, run_rx_i})
         2'b00:   gpio_o = atr_idle;
         2'b01:   gpio_o = atr_rx;
         2'b10:   gpio_o = atr_tx;
         default: gpio_o = atr_fdx;
      endcase
   end

   // Pin sample for readback
   always_ff @(posedge dsp_clk) begin
      gpio_readback_o <= gpio_i;
   end

endmodule

// ==== readback_mux.sv ====
// Registered readback mux selecting one of sixteen 32-bit status words
`timescale 1ns/1ns

module readback_mux (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic [radio_ctrl_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   input  logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_rb_i,
   input  logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time_i,
   input  logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time_pps_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] status_i,
   output logic [radio_ctrl_pkg::SET_DATA_W-1:0] rb_data_o
);

   logic [radio_ctrl_pkg::SET_DATA_W-1:0] rb_sel;

   // Words of blocks not in this core read zero
   always_comb begin
      case (rb_addr_i)
         radio_ctrl_pkg::RB_GPIO:    rb_sel = gpio_rb_i;
         radio_ctrl_pkg::RB_TIME_HI: rb_sel = vita_time_i[63:32];
         radio_ctrl_pkg::RB_TIME_LO: rb_sel = vita_time_i[31:0];
         radio_ctrl_pkg::RB_COMPAT:  rb_sel = radio_ctrl_pkg::COMPAT_NUM;
         radio_ctrl_pkg::RB_STATUS:  rb_sel = status_i;
         radio_ctrl_pkg::RB_PPS_HI:  rb_sel = vita_time_pps_i[63:32];
         radio_ctrl_pkg::RB_PPS_LO:  rb_sel = vita_time_pps_i[31:0];
         default:                    rb_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= rb_sel;
      end
   end

endmodule

// ==== radio_ctrl_core.sv ====
// Radio control plane top, settings bus fan-out to misc, time, GPIO and readback blocks
`timescale 1ns/1ns

module radio_ctrl_core (
   input  logic                                  dsp_clk,
   input  logic                                  rst_n_i,
   input  logic                                  set_stb_i,
   input  logic [radio_ctrl_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [radio_ctrl_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic [radio_ctrl_pkg::RB_ADDR_W-1:0]  rb_addr_i,
   input  logic                                  pps_i,
   input  logic                                  run_rx_i,
   input  logic                                  run_tx_i,
   input  logic                                  clk_status_i,
   input  logic                                  serdes_link_up_i,
   input  logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_i,
   output logic                                  ser_enable_o,
   output logic                                  ser_prbsen_o,
   output logic                                  ser_loopen_o,
   output logic                                  ser_rx_en_o,
   output logic                                  adc_oe_a_o,
   output logic                                  adc_on_a_o,
   output logic                                  adc_oe_b_o,
   output logic                                  adc_on_b_o,
   output logic                                  phy_reset_n_o,
   output logic [radio_ctrl_pkg::LED_W-1:0]      leds_o,
   output logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_o,
   output logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_oe_o,
   output logic                                  pps_int_o,
   output logic [radio_ctrl_pkg::SET_DATA_W-1:0] rb_data_o
);

   logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time;
   logic [radio_ctrl_pkg::TIME_W-1:0]     vita_time_pps;
   logic                                  good_sync;
   logic [radio_ctrl_pkg::GPIO_W-1:0]     gpio_readback;
   logic [radio_ctrl_pkg::SET_DATA_W-1:0] status;

   ////////////////////////////////////////////////////////////////////////////
   // Misc control and LEDs
   misc_ctrl u_misc (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .good_sync_i(good_sync),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // VITA time
   vita_time_64 u_time (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o), .good_sync_o(good_sync)
   );

   ////////////////////////////////////////////////////////////////////////////
   // GPIO and readback
   gpio_atr u_gpio (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .gpio_i(gpio_i),
      .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .gpio_readback_o(gpio_readback)
   );

   // Clock status at bit 11, SERDES link at bit 10
   assign status = {20'd0, clk_status_i, serdes_link_up_i, 10'd0};

   readback_mux u_rb (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .rb_addr_i(rb_addr_i),
      .gpio_rb_i(gpio_readback), .vita_time_i(vita_time),
      .vita_time_pps_i(vita_time_pps), .status_i(status), .rb_data_o(rb_data_o)
   );

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and power-on reset source for the radio control core
`timescale 1ns/1ns

module tb_clk_gen (
   output logic dsp_clk,
   output logic rst_n_o
);

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 4;

   initial begin
      dsp_clk = 1'b0;
      forever #HALF_PERIOD dsp_clk = ~dsp_clk;
   end

   // Reset released on a falling edge, away from the sampling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      @(negedge dsp_clk);
      rst_n_o = 1'b1;
   end

endmodule

// ==== radio_ctrl_core_tb.sv ====
// Testbench for the radio control core, programs each block over the settings bus and checks it
`timescale 1ns/1ns

module radio_ctrl_core_tb;

   logic        dsp_clk;
   logic        rst_n;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [3:0]  rb_addr_i;
   logic        pps_i;
   logic        run_rx_i;
   logic        run_tx_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic [31:0] gpio_i;
   logic        ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   logic        phy_reset_n_o;
   logic [7:0]  leds_o;
   logic [31:0] gpio_o;
   logic [31:0] gpio_oe_o;
   logic        pps_int_o;
   logic [31:0] rb_data_o;

   integer      seed;
   int          i;
   logic [31:0] rnd;
   logic [31:0] rd_hi;
   logic [31:0] rd_lo;
   logic [63:0] t_load;
   logic [63:0] t_read;
   logic [63:0] snap;
   logic [31:0] atr [4];
   logic [31:0] ddr;
   logic [7:0]  led_sw;
   logic [7:0]  led_src;
   logic        sync_seen;
   logic        pps_seen;
   logic [3:0]  ser_bits;
   logic [3:0]  adc_bits;

   tb_clk_gen u_clk (.dsp_clk(dsp_clk), .rst_n_o(rst_n));

   radio_ctrl_core uut (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .rb_addr_i(rb_addr_i), .pps_i(pps_i), .run_rx_i(run_rx_i),
      .run_tx_i(run_tx_i), .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .gpio_i(gpio_i), .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o), .adc_oe_a_o(adc_oe_a_o),
      .adc_on_a_o(adc_on_a_o), .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o),
      .pps_int_o(pps_int_o), .rb_data_o(rb_data_o)
   );

   assign ser_bits = {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o};
   assign adc_bits = {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o};

   task automatic stop_with_failure();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] idx, output logic [31:0] data);
      @(negedge dsp_clk);
      rb_addr_i = idx;
      @(negedge dsp_clk);
      data = rb_data_o;
   endtask

   // Hardware LED word from tx, rx, clock status and the sync-qualified link
   function automatic logic [7:0] led_hw_word(input logic sync);
      led_hw_word    = 8'h00;
      led_hw_word[4] = run_tx_i;
      led_hw_word[3] = run_rx_i;
      led_hw_word[2] = clk_status_i;
      led_hw_word[1] = serdes_link_up_i & sync;
   endfunction

   // PPS interrupt is a single-cycle pulse
   assert property (@(posedge dsp_clk) disable iff (!rst_n) pps_int_o |=> !pps_int_o)
      else begin
         $display("pps_int_o stayed high for more than one cycle");
         stop_with_failure();
      end

   initial begin
      seed = 32'ha707fad2;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      rb_addr_i = '0;
      pps_i = 1'b0;
      run_rx_i = 1'b0;
      run_tx_i = 1'b1;
      clk_status_i = 1'b1;
      serdes_link_up_i = 1'b1;
      gpio_i = '0;
      sync_seen = 1'b0;
      pps_seen = 1'b0;

      for (i = 0; i < 20 && !rst_n; i++) @(negedge dsp_clk);
      if (!rst_n) begin
         $display("Timeout waiting for reset release");
         stop_with_failure();
      end
      @(negedge dsp_clk);

      /////////////////////////////////////////////////////////////////////////
      // Reset state
      check_value("ser_bits", ser_bits, 0);
      check_value("adc_bits", adc_bits, 0);
      check_value("phy_reset_n_o", phy_reset_n_o, 1);
      check_value("leds_o", leds_o, led_hw_word(1'b0) & 8'h1E);
      check_value("gpio_oe_o", gpio_oe_o, 0);
      check_value("pps_int_o", pps_int_o, 0);

      /////////////////////////////////////////////////////////////////////////
      // Misc registers and unmapped writes
      rnd = $random(seed);
      write_setting(8'd1, rnd);
      check_value("ser_bits", ser_bits, rnd[3:0]);
      rnd = $random(seed);
      write_setting(8'd2, rnd);
      check_value("adc_bits", adc_bits, rnd[3:0]);
      write_setting(8'd4, 32'd1);
      check_value("phy_reset_n_o", phy_reset_n_o, 0);
      write_setting(8'd4, 32'd0);
      check_value("phy_reset_n_o", phy_reset_n_o, 1);
      snap = {ser_bits, adc_bits, phy_reset_n_o, leds_o, gpio_oe_o};
      write_setting(8'd5, $random(seed));
      write_setting(8'd189, $random(seed));
      check_value("misc outputs", {ser_bits, adc_bits, phy_reset_n_o, leds_o, gpio_oe_o}, snap);

      /////////////////////////////////////////////////////////////////////////
      // LED select between hardware and software bits
      led_sw  = $random(seed);
      led_src = $random(seed);
      write_setting(8'd3, {24'd0, led_sw});
      write_setting(8'd6, {24'd0, led_src});
      check_value("leds_o", leds_o, (led_src & led_hw_word(1'b0)) | (~led_src & led_sw));
      run_rx_i = 1'b1;
      @(negedge dsp_clk);
      check_value("leds_o", leds_o, (led_src & led_hw_word(1'b0)) | (~led_src & led_sw));

      /////////////////////////////////////////////////////////////////////////
      // ATR GPIO with the array in idle, rx, tx, fdx order
      for (i = 0; i < 4; i++) begin
         atr[i] = $random(seed);
         write_setting(8'd184 + i[7:0], atr[i]);
      end
      ddr = $random(seed);
      write_setting(8'd188, ddr);
      for (i = 0; i < 4; i++) begin
         @(negedge dsp_clk);
         {run_tx_i, run_rx_i} = i[1:0];
         @(negedge dsp_clk);
         check_value("gpio_o", gpio_o, atr[i]);
         check_value("gpio_oe_o", gpio_oe_o, ddr);
      end
      gpio_i = $random(seed);
      @(negedge dsp_clk);
      read_word(4'd9, rd_lo);
      check_value("rb_data_o gpio", rd_lo, gpio_i);
      run_rx_i = 1'b0;
      run_tx_i = 1'b1;

      /////////////////////////////////////////////////////////////////////////
      // Immediate time load, compat and status words
      t_load = {$random(seed), $random(seed) & 32'h7FFF_FFFF};
      write_setting(8'd10, t_load[63:32]);
      write_setting(8'd11, t_load[31:0]);
      write_setting(8'd12, 32'd1);
      read_word(4'd10, rd_hi);
      read_word(4'd11, rd_lo);
      t_read = {rd_hi, rd_lo};
      assert (t_read >= t_load && t_read < t_load + 64'd20) else begin
         $display("Fail vita_time: got %h expected %h to %h", t_read, t_load, t_load + 64'd19);
         stop_with_failure();
      end
      read_word(4'd12, rd_lo);
      check_value("rb_data_o compat", rd_lo, 32'h0009_0000);
      // Link down so only the clock status bit is set
      serdes_link_up_i = 1'b0;
      read_word(4'd13, rd_lo);
      check_value("rb_data_o status", rd_lo, 32'h0000_0800);
      serdes_link_up_i = 1'b1;

      /////////////////////////////////////////////////////////////////////////
      // Load armed for the next PPS edge
      t_load = {$random(seed), $random(seed)};
      write_setting(8'd10, t_load[63:32]);
      write_setting(8'd11, t_load[31:0]);
      write_setting(8'd12, 32'd0);
      @(negedge dsp_clk);
      pps_i = 1'b1;
      for (i = 0; i < 20 && !pps_seen; i++) begin
         @(negedge dsp_clk);
         pps_seen = pps_int_o;
      end
      if (!pps_seen) begin
         $display("Timeout waiting for pps_int_o");
         stop_with_failure();
      end
      sync_seen = 1'b1;
      pps_i = 1'b0;
      read_word(4'd14, rd_hi);
      read_word(4'd15, rd_lo);
      check_value("vita_time_pps", {rd_hi, rd_lo}, t_load);

      // All LEDs on hardware so bit 1 shows the qualified link
      write_setting(8'd6, 32'hFF);
      check_value("leds_o", leds_o, led_hw_word(sync_seen));
      serdes_link_up_i = 1'b0;
      @(negedge dsp_clk);
      check_value("leds_o", leds_o, led_hw_word(sync_seen));
      serdes_link_up_i = 1'b1;
      clk_status_i = 1'b0;
      @(negedge dsp_clk);
      check_value("leds_o", leds_o, led_hw_word(sync_seen));
      clk_status_i = 1'b1;
      @(negedge dsp_clk);
      check_value("leds_o[1]", leds_o[1], 1);

      $display("All checks passed");
      $finish;
   end

endmodule

// ==== radio_ctrl_core.f ====
radio_ctrl_pkg.sv
setting_reg.sv
misc_ctrl.sv
vita_time_64.sv
gpio_atr.sv
readback_mux.sv
radio_ctrl_core.sv
tb_clk_gen.sv
radio_ctrl_core_tb.sv

// ==== Bender.yml ====
package:
  name: radio_ctrl_core

sources:
  - radio_ctrl_pkg.sv
  - setting_reg.sv
  - misc_ctrl.sv
  - vita_time_64.sv
  - gpio_atr.sv
  - readback_mux.sv
  - radio_ctrl_core.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - radio_ctrl_core_tb.sv
